// ==== dv/sdram_mux_testdata.txt ====
// slot mask, kind (0 read, 1 write, 2 clear cache), slot address, write data,
// write mask (bits active low, bit 0 low byte), vblank; all hex, offsets 0x00/0x40/0x80/0xc0
1 0 000010 0000 3 0
2 0 000011 0000 3 0
4 0 000020 0000 3 0
8 0 000025 0000 3 0
// other half of each cached pair
1 0 000011 0000 3 0
2 0 000010 0000 3 0
4 0 000021 0000 3 0
8 0 000024 0000 3 0
0 2 000000 0000 3 1
// all slots in one cycle
F 0 000030 0000 3 0
F 0 000031 0000 3 1
F 0 000007 0000 3 0
// masked writes, then reads that overlap
8 1 000006 A55A 2 0
8 0 000006 0000 3 0
2 1 000002 1234 1 0
1 0 000042 0000 3 0
2 0 000002 0000 3 0
A 1 000010 BEEF 0 0
F 0 000010 0000 3 0
F 0 000011 0000 3 1
// cache clear
1 2 000000 0000 3 0
1 0 000011 0000 3 0
5 2 000000 0000 3 1
5 0 000010 0000 3 0
8 1 000001 7E81 1 0
4 0 000041 0000 3 0
4 0 000040 0000 3 0
8 0 000001 0000 3 0
2 1 00003F 00FF 2 0
6 0 00003F 0000 3 0
1 0 00007F 0000 3 0
0 2 000000 0000 3 1

// ==== src.f ====
logic/slot_pkg.sv
logic/sdram_bus_pkg.sv
logic/slot_rq.sv
logic/slot_arbiter.sv
logic/sdram_mux_top.sv
dv/tb_clk_gen.sv
dv/tb_sdram_mux.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SDRAM slot mux testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_sdram_mux -o tb_sdram_mux_sim

out=$(./obj_dir/tb_sdram_mux_sim 2>&1 || true)
echo "$out"

# status comes from the pass line alone
echo "$out" | grep -q "^sim passed$"

// ==== dv/tb_sdram_mux.sv ====
// testbench for the SDRAM slot multiplexer: SDRAM model, file-driven slot traffic and result checks
`timescale 1ns/1ps

module tb_sdram_mux;

    localparam int NUM_SLOTS  = 4;
    localparam int MAX_LINES  = 64;
    localparam int LINE_WORDS = 6;

    logic                       clk;
    logic                       rst_n;
    logic                       vblank;
    slot_pkg::slot_req_t        slot_req    [NUM_SLOTS];
    sdram_bus_pkg::sdram_addr_t slot_offset [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]       slot_clr;
    slot_pkg::slot_rsp_t        slot_rsp    [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]       slot_active;
    sdram_bus_pkg::sdram_cmd_t  sdram_cmd;
    sdram_bus_pkg::sdram_rsp_t  sdram_rsp;
    logic                       refresh_en;

    logic [31:0]                line_words [MAX_LINES*LINE_WORDS];
    int                         n_lines = 0;
    logic [31:0]                rng_state = 32'd47417;
    slot_pkg::slot_word_t       sdram_mem [256];
    slot_pkg::slot_word_t       ref_mem   [256];
    int                         rd_count = 0;
    sdram_bus_pkg::sdram_addr_t cmd_log [$];
    logic [NUM_SLOTS-1:0]       grant_log [$];
    logic                       vblank_d = 1'b0;
    logic                       refresh_seen = 1'b0;

    tb_clk_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (16)
    ) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    // slots 1 and 3 may write
    sdram_mux_top #(
        .NUM_SLOTS     (NUM_SLOTS),
        .SLOT_WRITABLE (4'b1010),
        .CACHE_EN      (1'b1)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .slot_req    (slot_req),
        .slot_offset (slot_offset),
        .slot_clr    (slot_clr),
        .slot_rsp    (slot_rsp),
        .slot_active (slot_active),
        .sdram_cmd   (sdram_cmd),
        .sdram_rsp   (sdram_rsp),
        .refresh_en  (refresh_en)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // four possible delays starting at lo
    task automatic draw_delay(input int lo, output int cycles);
        rng_state = xorshift32(rng_state);
        cycles = lo + int'(rng_state[1:0]);
    endtask

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input slot_pkg::slot_word_t got,
                              input slot_pkg::slot_word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input sdram_bus_pkg::sdram_addr_t got,
                              input sdram_bus_pkg::sdram_addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_grant(input string name, input logic [NUM_SLOTS-1:0] got,
                               input logic [NUM_SLOTS-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // SDRAM controller model, one access at a time
    initial begin : sdram_model
        sdram_bus_pkg::sdram_cmd_t cmd;
        int                        wait_cycles;
        logic [7:0]                idx;
        sdram_rsp = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (sdram_cmd.req) begin
                cmd = sdram_cmd;
                cmd_log.push_back(cmd.addr);
                grant_log.push_back(slot_active);
                draw_delay(1, wait_cycles);
                repeat (wait_cycles - 1) @(posedge clk);
                sdram_rsp.ack <= 1'b1;
                @(posedge clk);
                sdram_rsp.ack <= 1'b0;
                draw_delay(2, wait_cycles);
                repeat (wait_cycles - 1) @(posedge clk);
                idx = cmd.addr[7:0];
                if (cmd.rnw) begin
                    idx[0] = 1'b0;
                    sdram_rsp.rdata <= {sdram_mem[idx + 8'd1], sdram_mem[idx]};
                    rd_count++;
                end else begin
                    // mask bits are active low
                    if (!cmd.wrmask[0]) begin
                        sdram_mem[idx][7:0] = cmd.wdata[7:0];
                    end
                    if (!cmd.wrmask[1]) begin
                        sdram_mem[idx][15:8] = cmd.wdata[15:8];
                    end
                end
                sdram_rsp.data_rdy <= 1'b1;
                @(posedge clk);
                sdram_rsp.data_rdy <= 1'b0;
            end
        end
    end

    // refresh_en follows vblank of the cycle before
    always @(posedge clk) begin
        if (refresh_en && !vblank_d) begin
            stop_on_error("refresh_en was high although vblank was low in the cycle before");
        end
        vblank_d <= vblank;
    end

    initial begin : watchdog
        wait (rst_n === 1'b1);
        #(n_lines * 40 * 20);
        stop_on_error($sformatf("timeout: %0d stimulus lines did not finish in time", n_lines));
    end

    initial begin : stimulus
        logic [NUM_SLOTS-1:0]       sel;
        logic [1:0]                 kind;
        slot_pkg::slot_addr_t       addr;
        slot_pkg::slot_word_t       data;
        slot_pkg::slot_mask_t       mask;
        logic                       vb;
        sdram_bus_pkg::sdram_addr_t full;
        sdram_bus_pkg::sdram_addr_t even;
        slot_pkg::slot_req_t        rq;
        sdram_bus_pkg::sdram_addr_t exp_cmds [$];
        logic [NUM_SLOTS-1:0]       exp_grants [$];
        slot_pkg::slot_word_t       exp_data [NUM_SLOTS];
        sdram_bus_pkg::sdram_addr_t exp_tag  [NUM_SLOTS];
        logic [NUM_SLOTS-1:0]       exp_valid;
        logic [NUM_SLOTS-1:0]       pending;
        logic                       has_miss;
        int                         exp_reads;
        int                         waited;
        int                         base;

        vblank   = 1'b0;
        slot_clr = '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            slot_req[s]    = '0;
            slot_offset[s] = sdram_bus_pkg::sdram_addr_t'(s * 64);
        end
        for (int i = 0; i < MAX_LINES * LINE_WORDS; i++) begin
            line_words[i] = '1;
        end
        $readmemh("dv/sdram_mux_testdata.txt", line_words);
        while (n_lines < MAX_LINES && line_words[n_lines * LINE_WORDS] != '1) begin
            n_lines++;
        end
        for (int i = 0; i < 256; i++) begin
            rng_state  = xorshift32(rng_state);
            sdram_mem[i] = rng_state[15:0];
            ref_mem[i]   = rng_state[15:0];
        end
        exp_valid = '0;
        exp_reads = 0;

        wait (rst_n === 1'b1);
        @(posedge clk);
        for (int ln = 0; ln < n_lines; ln++) begin
            base = ln * LINE_WORDS;
            sel  = line_words[base][NUM_SLOTS-1:0];
            kind = line_words[base + 1][1:0];
            addr = line_words[base + 2][21:0];
            data = line_words[base + 3][15:0];
            mask = line_words[base + 4][1:0];
            vb   = line_words[base + 5][0];
            has_miss = 1'b0;

            // expected commands, cache contents and data
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (sel[s]) begin
                    full = slot_offset[s] + addr;
                    even = {full[21:1], 1'b0};
                    if (kind == 2'd2) begin
                        exp_valid[s] = 1'b0;
                    end else if (kind == 2'd1) begin
                        exp_cmds.push_back(full);
                        exp_grants.push_back(NUM_SLOTS'(1) << s);
                        exp_valid[s] = 1'b0;
                        has_miss     = 1'b1;
                        if (!mask[0]) begin
                            ref_mem[full[7:0]][7:0] = data[7:0];
                        end
                        if (!mask[1]) begin
                            ref_mem[full[7:0]][15:8] = data[15:8];
                        end
                    end else begin
                        if (!(exp_valid[s] && exp_tag[s] == even)) begin
                            exp_cmds.push_back(even);
                            exp_grants.push_back(NUM_SLOTS'(1) << s);
                            exp_reads++;
                            exp_valid[s] = 1'b1;
                            exp_tag[s]   = even;
                            has_miss     = 1'b1;
                        end
                        exp_data[s] = ref_mem[full[7:0]];
                    end
                end
            end

            if (kind == 2'd2) begin
                slot_clr <= sel;
                @(posedge clk);
                slot_clr <= '0;
            end else begin
                rq.cs     = 1'b1;
                rq.wr     = (kind == 2'd1);
                rq.addr   = addr;
                rq.din    = data;
                rq.wrmask = mask;
                for (int s = 0; s < NUM_SLOTS; s++) begin
                    if (sel[s]) begin
                        slot_req[s] <= rq;
                    end
                end
                pending = sel;
                waited  = 0;
                while (pending != '0) begin
                    @(posedge clk);
                    waited++;
                    // by the third edge the arbiter has seen the need
                    if (has_miss && waited >= 3 && refresh_en) begin
                        stop_on_error("refresh_en was high while slot requests were waiting");
                    end
                    for (int s = 0; s < NUM_SLOTS; s++) begin
                        if (pending[s] && slot_rsp[s].ok) begin
                            if (kind == 2'd0) begin
                                check_word($sformatf("slot_rsp[%0d].dout", s),
                                           slot_rsp[s].dout, exp_data[s]);
                            end
                            slot_req[s].cs <= 1'b0;
                            pending[s] = 1'b0;
                        end
                    end
                end
            end

            // vblank of a line covers its idle window and the next line's requests
            vblank <= vb;

            repeat (3) begin
                @(posedge clk);
                if (vb && refresh_en) begin
                    refresh_seen = 1'b1;
                end
            end

            check_count("sdram command count", cmd_log.size(), exp_cmds.size());
            for (int k = 0; k < exp_cmds.size(); k++) begin
                check_addr($sformatf("sdram_cmd.addr #%0d", k), cmd_log[k], exp_cmds[k]);
                check_grant($sformatf("slot_active #%0d", k), grant_log[k], exp_grants[k]);
            end
            check_count("sdram read count", rd_count, exp_reads);
            cmd_log.delete();
            grant_log.delete();
            exp_cmds.delete();
            exp_grants.delete();
        end

        if (refresh_seen) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_on_error("refresh_en never rose during an idle window with vblank high");
        end
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
// testbench clock and reset source: free-running clock, active-low reset held for a set number of cycles
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== logic/sdram_mux_top.sv ====
// SDRAM slot multiplexer top level: per-slot request units sharing one controller port
`timescale 1ns/1ps

module sdram_mux_top #(
    parameter int                 NUM_SLOTS     = 4,
    parameter bit [NUM_SLOTS-1:0] SLOT_WRITABLE = '0,
    parameter bit                 CACHE_EN      = 1'b1
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       vblank,
    input  slot_pkg::slot_req_t        slot_req    [NUM_SLOTS],
    input  sdram_bus_pkg::sdram_addr_t slot_offset [NUM_SLOTS],
    input  logic [NUM_SLOTS-1:0]       slot_clr,
    output slot_pkg::slot_rsp_t        slot_rsp    [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0]       slot_active,
    output sdram_bus_pkg::sdram_cmd_t  sdram_cmd,
    input  sdram_bus_pkg::sdram_rsp_t  sdram_rsp,
    output logic                       refresh_en
);

    logic [NUM_SLOTS-1:0]       need;
    logic [NUM_SLOTS-1:0]       need_rnw;
    sdram_bus_pkg::sdram_addr_t need_addr   [NUM_SLOTS];
    slot_pkg::slot_word_t       need_wdata  [NUM_SLOTS];
    slot_pkg::slot_mask_t       need_wrmask [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]       done;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        slot_rq #(
            .CACHE_EN (CACHE_EN),
            .WRITABLE (SLOT_WRITABLE[i])
        ) u_slot_rq (
            .clk         (clk),
            .rst_n       (rst_n),
            .slot_req    (slot_req[i]),
            .offset      (slot_offset[i]),
            .clr         (slot_clr[i]),
            .slot_rsp    (slot_rsp[i]),
            .need        (need[i]),
            .need_rnw    (need_rnw[i]),
            .need_addr   (need_addr[i]),
            .need_wdata  (need_wdata[i]),
            .need_wrmask (need_wrmask[i]),
            .done        (done[i]),
            // read burst shared by every slot
            .rdata       (sdram_rsp.rdata)
        );
    end

    slot_arbiter #(
        .NUM_SLOTS (NUM_SLOTS)
    ) u_slot_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .need        (need),
        .need_rnw    (need_rnw),
        .need_addr   (need_addr),
        .need_wdata  (need_wdata),
        .need_wrmask (need_wrmask),
        .done        (done),
        .sdram_cmd   (sdram_cmd),
        .sdram_rsp   (sdram_rsp),
        .grant       (slot_active),
        .refresh_en  (refresh_en)
    );

endmodule

// ==== logic/slot_arbiter.sv ====
// fixed-priority arbiter: grants the lowest requesting slot, drives the SDRAM command, routes done
`timescale 1ns/1ps

module slot_arbiter #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       vblank,
    input  logic [NUM_SLOTS-1:0]       need,
    input  logic [NUM_SLOTS-1:0]       need_rnw,
    input  sdram_bus_pkg::sdram_addr_t need_addr   [NUM_SLOTS],
    input  slot_pkg::slot_word_t       need_wdata  [NUM_SLOTS],
    input  slot_pkg::slot_mask_t       need_wrmask [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0]       done,
    output sdram_bus_pkg::sdram_cmd_t  sdram_cmd,
    input  sdram_bus_pkg::sdram_rsp_t  sdram_rsp,
    output logic [NUM_SLOTS-1:0]       grant,
    output logic                       refresh_en
);

    localparam int IDX_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

    typedef enum logic [1:0] {
        idle,
        issue,
        wait_data
    } state_t;

    state_t                     state;
    logic [IDX_W-1:0]           sel_idx;
    logic [NUM_SLOTS-1:0]       sel_oh;

    logic                       cmd_req;
    logic                       cmd_rnw;
    sdram_bus_pkg::sdram_addr_t cmd_addr;
    slot_pkg::slot_word_t       cmd_wdata;
    slot_pkg::slot_mask_t       cmd_wrmask;

    // lowest index wins, so scan downwards and let the last hit stand
    always_comb begin
        sel_idx = '0;
        sel_oh  = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (need[i]) begin
                sel_idx    = IDX_W'(i);
                sel_oh     = '0;
                sel_oh[i]  = 1'b1;
            end
        end
    end

    // completion goes straight back so the slot answers in the next cycle
    assign done = (state != idle && sdram_rsp.data_rdy) ? grant : '0;

    assign sdram_cmd = '{
        req:    cmd_req,
        rnw:    cmd_rnw,
        addr:   cmd_addr,
        wdata:  cmd_wdata,
        wrmask: cmd_wrmask
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= idle;
            grant      <= '0;
            cmd_req    <= 1'b0;
            refresh_en <= 1'b0;
        end else begin
            refresh_en <= 1'b0;
            case (state)
                idle: begin
                    if (|need) begin
                        grant   <= sel_oh;
                        cmd_req <= 1'b1;
                        state   <= issue;
                    end else begin
                        refresh_en <= vblank;
                    end
                end
                issue: begin
                    if (sdram_rsp.ack) begin
                        cmd_req <= 1'b0;
                        // data_rdy may come together with ack
                        if (sdram_rsp.data_rdy) begin
                            grant <= '0;
                            state <= idle;
                        end else begin
                            state <= wait_data;
                        end
                    end
                end
                wait_data: begin
                    if (sdram_rsp.data_rdy) begin
                        grant <= '0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && |need) begin
            cmd_rnw    <= need_rnw[sel_idx];
            cmd_addr   <= need_addr[sel_idx];
            cmd_wdata  <= need_wdata[sel_idx];
            cmd_wrmask <= need_wrmask[sel_idx];
        end
    end

    // the granted slot holds its need until done
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && (grant & ~need) == '0);

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_cmd.req && !sdram_rsp.ack |=> sdram_cmd.req && $stable(sdram_cmd));

    // the controller only completes what was issued
    a_no_rdy_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state == idle |-> !sdram_rsp.data_rdy);

endmodule

// ==== logic/slot_rq.sv ====
// one client slot: adds the region offset, keeps a one-entry read cache and holds the SDRAM need
`timescale 1ns/1ps

module slot_rq #(
    parameter bit CACHE_EN = 1'b1,
    parameter bit WRITABLE = 1'b0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  slot_pkg::slot_req_t         slot_req,
    input  sdram_bus_pkg::sdram_addr_t  offset,
    input  logic                        clr,
    output slot_pkg::slot_rsp_t         slot_rsp,
    output logic                        need,
    output logic                        need_rnw,
    output sdram_bus_pkg::sdram_addr_t  need_addr,
    output slot_pkg::slot_word_t        need_wdata,
    output slot_pkg::slot_mask_t        need_wrmask,
    input  logic                        done,
    input  sdram_bus_pkg::sdram_rdata_t rdata
);

    typedef enum logic [1:0] {
        idle,
        wait_sdram,
        respond
    } state_t;

    state_t                      state;
    logic                        ok_q;
    slot_pkg::slot_word_t        dout_q;
    logic                        valid_q;
    sdram_bus_pkg::sdram_addr_t  tag_q;
    sdram_bus_pkg::sdram_rdata_t cache_q;

    sdram_bus_pkg::sdram_addr_t  full_addr;
    sdram_bus_pkg::sdram_addr_t  even_addr;
    logic                        eff_wr;
    logic                        start;
    logic                        hit;

    assign full_addr = offset + sdram_bus_pkg::sdram_addr_t'(slot_req.addr);
    assign even_addr = {full_addr[21:1], 1'b0};

    // read-only slots turn wr into a read
    assign eff_wr = WRITABLE && slot_req.wr;

    // ok_q blocks a second start on the cs still held in the ok cycle
    assign start = slot_req.cs && !ok_q;
    assign hit   = CACHE_EN && valid_q && !eff_wr && (tag_q == even_addr);

    assign slot_rsp = '{ok: ok_q, dout: dout_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= idle;
            ok_q    <= 1'b0;
            need    <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            ok_q <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        if (hit) begin
                            state <= respond;
                        end else begin
                            need  <= 1'b1;
                            state <= wait_sdram;
                        end
                    end
                end
                respond: begin
                    ok_q  <= 1'b1;
                    state <= idle;
                end
                wait_sdram: begin
                    if (done) begin
                        need  <= 1'b0;
                        ok_q  <= 1'b1;
                        state <= idle;
                        // a read refills the entry, a write drops it
                        valid_q <= need_rnw && CACHE_EN;
                    end
                end
                default: state <= idle;
            endcase
            if (clr) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start && !hit) begin
            need_rnw    <= !eff_wr;
            need_addr   <= eff_wr ? full_addr : even_addr;
            need_wdata  <= slot_req.din;
            need_wrmask <= eff_wr ? slot_req.wrmask : slot_pkg::slot_mask_t'('1);
        end
        if (state == respond) begin
            dout_q <= full_addr[0] ? cache_q[31:16] : cache_q[15:0];
        end
        if (state == wait_sdram && done && need_rnw) begin
            tag_q   <= need_addr;
            cache_q <= rdata;
            dout_q  <= full_addr[0] ? rdata[31:16] : rdata[15:0];
        end
    end

    // done only reaches a slot whose need is already held
    a_need_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> need && !$rose(need));

    a_ro_slot_write: assert property (@(posedge clk) disable iff (!rst_n)
        slot_req.cs |-> (WRITABLE || !slot_req.wr));

endmodule

// ==== logic/sdram_bus_pkg.sv ====
// SDRAM controller port types, used by the arbiter, the slot units and the mux top level
package sdram_bus_pkg;

    // full SDRAM word address
    typedef logic [21:0] sdram_addr_t;

    // read burst of two words, even address in the low half
    typedef logic [31:0] sdram_rdata_t;

    // req held until ack, payload stable while req is high
    typedef struct packed {
        logic                 req;
        logic                 rnw;
        sdram_addr_t          addr;
        slot_pkg::slot_word_t wdata;
        slot_pkg::slot_mask_t wrmask;
    } sdram_cmd_t;

    // data_rdy pulses once per access
    typedef struct packed {
        logic         ack;
        logic         data_rdy;
        sdram_rdata_t rdata;
    } sdram_rsp_t;

endpackage

// ==== logic/slot_pkg.sv ====
// client slot types, used by slot_rq and sdram_mux_top for the per-slot request and response ports
package slot_pkg;

    // word address inside one slot region
    typedef logic [21:0] slot_addr_t;

    // every slot carries 16-bit words
    typedef logic [15:0] slot_word_t;

    // byte write mask, each bit active low
    typedef logic [1:0] slot_mask_t;

    // held by the client until ok pulses
    typedef struct packed {
        logic       cs;
        logic       wr;
        slot_addr_t addr;
        slot_word_t din;
        slot_mask_t wrmask;
    } slot_req_t;

    // dout valid in the ok cycle and kept until the next request
    typedef struct packed {
        logic       ok;
        slot_word_t dout;
    } slot_rsp_t;

endpackage
